/* dv/vfront_tb_model.svh */
////////////////////////////////////////////////////////////
// Reference model of the vector front end: expected result
// queue, configuration rules and the result checker
////////////////////////////////////////////////////////////

`ifndef VFRONT_TB_MODEL_SVH
`define VFRONT_TB_MODEL_SVH

typedef struct {
  logic [3:0]  id;
  logic [4:0]  rd;
  logic        we;
  logic [31:0] data;
  logic        is_cfg;
  logic [8:0]  vtype;
  logic        committed;
} exp_t;

exp_t        exp_q[$];
logic        held_valid;
logic [3:0]  held_id;
logic [31:0] held_data;

// 0 other, 1 vsetvli, 2 vsetivli, 3 vsetvl
function automatic int ref_kind(logic [31:0] instr);
  if (instr[6:0] != `VFRONT_OPV || instr[14:12] != 3'b111) return 0;
  if (!instr[31]) return 1;
  if (instr[30]) return 2;
  if (instr[30:25] == 6'd0) return 3;
  return 0;
endfunction

task automatic model_issue(input logic [31:0] instr, input logic [3:0] id,
                           input logic [31:0] rs1, input logic [31:0] rs2);
  exp_t        e;
  int          k;
  logic [31:0] raw;
  logic [31:0] vmax;
  logic [31:0] avl;
  logic        legal;
  if (instr[6:0] != `VFRONT_OPV) return;
  k = ref_kind(instr);
  raw = (k == 1) ? {21'd0, instr[30:20]} : (k == 2) ? {22'd0, instr[29:20]} : rs2;
  legal = (raw[31:8] == 24'd0) && !raw[5] && !raw[2];
  // VLEN / SEW * LMUL
  vmax = (32'd128 / (32'd8 << raw[4:3])) * (32'd1 << raw[1:0]);
  if (k == 2) avl = {27'd0, instr[19:15]};
  else if (instr[19:15] == 5'd0) avl = vmax;
  else avl = rs1;
  e.id = id;
  e.rd = instr[11:7];
  e.is_cfg = (k != 0);
  e.we = e.is_cfg && (instr[11:7] != 5'd0);
  e.data = !e.is_cfg ? 32'd0 : !legal ? 32'd0 : (avl < vmax) ? avl : vmax;
  e.vtype = legal ? {1'b0, raw[7:0]} : 9'h100;
  e.committed = 1'b0;
  exp_q.push_back(e);
endtask

// Oldest uncommitted entry gets committed
function automatic logic [3:0] model_commit();
  foreach (exp_q[i]) begin
    if (!exp_q[i].committed) begin
      exp_q[i].committed = 1'b1;
      return exp_q[i].id;
    end
  end
  return 4'd0;
endfunction

function automatic void model_kill();
  for (int i = exp_q.size() - 1; i >= 0; i--) begin
    if (!exp_q[i].committed) exp_q.delete(i);
  end
endfunction

// Sampled at the falling edge
task automatic check_result();
  exp_t e;
  if (held_valid) begin
    check_val("result_valid_o", result_valid_o, 1);
    check_val("result_id_o", result_id_o, held_id);
    check_val("result_data_o", result_data_o, held_data);
  end
  held_valid = result_valid_o && !result_ready_i;
  held_id    = result_id_o;
  held_data  = result_data_o;
  if (result_valid_o && result_ready_i) begin
    if (exp_q.size() == 0 || !exp_q[0].committed) begin
      $display("Unexpected result for id %0d with nothing committed outstanding", result_id_o);
      errors++;
    end else begin
      e = exp_q.pop_front();
      check_val("result_id_o", result_id_o, e.id);
      check_val("result_rd_o", result_rd_o, e.rd);
      check_val("result_we_o", result_we_o, e.we);
      check_val("result_data_o", result_data_o, e.data);
      if (e.is_cfg) begin
        check_val("vl_o", vl_o, e.data);
        check_val("vtype_o", vtype_o, e.vtype);
      end
    end
  end
endtask

`endif

/* dv/vfront_tb.sv */
////////////////////////////////////////////////////////////
// Testbench of the vector front end: random issue, commit,
// kill and back-pressure against the reference model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "vfront_macros.svh"

module vfront_tb;

  // Instructions issued per test, in order
  localparam int N_ISSUED    = 3 + 12 + 10 + 6 + 5 + 16;
  localparam int CYCLE_LIMIT = 20 * N_ISSUED + 500;

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  logic        issue_valid_i = 1'b0;
  logic [31:0] issue_instr_i = '0;
  logic [3:0]  issue_id_i = '0;
  logic        issue_ready_o, issue_accept_o, issue_writeback_o;
  logic [1:0]  issue_register_read_o;
  logic        register_valid_i = 1'b0;
  logic [3:0]  register_id_i = '0;
  logic [31:0] register_rs1_i = '0;
  logic [31:0] register_rs2_i = '0;
  logic        register_ready_o;
  logic        commit_valid_i = 1'b0;
  logic [3:0]  commit_id_i = '0;
  logic        commit_kill_i = 1'b0;
  logic        result_valid_o, result_we_o;
  logic [3:0]  result_id_o;
  logic [4:0]  result_rd_o;
  logic [31:0] result_data_o;
  logic        result_ready_i = 1'b0;
  logic [31:0] vl_o;
  logic [8:0]  vtype_o;

  integer     seed = 32'h8881;
  int         errors = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         test_err_base = 0;
  int         cycles = 0;
  int         rr_mode = 0;
  logic [3:0] next_id = '0;

  vfront_top vfront_top_inst (.*);

  always #50 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  `include "vfront_tb_model.svh"

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: no progress after %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Result back-pressure and checking
  always begin
    @(posedge clk_i);
    #1;
    result_ready_i = (rr_mode == 0) ? 1'b1 : (rr_mode == 2) ? 1'b0 : 1'($random(seed));
    @(negedge clk_i);
    if (rst_ni) check_result();
  end

  ////////////////////////////////////////////////////////////
  // Drivers, all start and end 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic issue(input logic [31:0] instr, input logic [31:0] rs1,
                       input logic [31:0] rs2, output int waited);
    int k;
    k = ref_kind(instr);
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_id_i    = next_id;
    waited = 0;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      waited++;
      @(negedge clk_i);
    end
    check_val("issue_accept_o", issue_accept_o, instr[6:0] == `VFRONT_OPV);
    check_val("issue_writeback_o", issue_writeback_o, k != 0 && instr[11:7] != 5'd0);
    check_val("issue_register_read_o", issue_register_read_o,
              (k == 1) ? 32'd1 : (k == 3) ? 32'd3 : 32'd0);
    model_issue(instr, next_id, rs1, rs2);
    step();
    issue_valid_i = 1'b0;
    next_id++;
  endtask

  task automatic commit_next();
    commit_valid_i = 1'b1;
    commit_id_i    = model_commit();
    step();
    commit_valid_i = 1'b0;
  endtask

  task automatic kill_all();
    commit_valid_i = 1'b1;
    commit_kill_i  = 1'b1;
    model_kill();
    step();
    commit_valid_i = 1'b0;
    commit_kill_i  = 1'b0;
  endtask

  // Issue is probed while the AVL register is still missing
  task automatic send_regs_late(input logic [3:0] id, input logic [31:0] rs1,
                                input logic [31:0] rs2, input int delay);
    issue_valid_i = 1'b1;
    issue_instr_i = {25'h0, `VFRONT_OPV};
    issue_id_i    = next_id;
    repeat (delay) begin
      @(negedge clk_i);
      check_val("issue_ready_o", issue_ready_o, 0);
      check_val("register_ready_o", register_ready_o, 0);
      step();
    end
    register_valid_i = 1'b1;
    register_id_i    = id;
    register_rs1_i   = rs1;
    register_rs2_i   = rs2;
    @(negedge clk_i);
    check_val("issue_ready_o", issue_ready_o, 0);
    check_val("register_ready_o", register_ready_o, 1);
    step();
    register_valid_i = 1'b0;
    issue_valid_i    = 1'b0;
  endtask

  function automatic logic [10:0] rand_zimm();
    logic [10:0] z;
    z = 11'($random(seed));
    // Mostly legal SEW and LMUL
    if (($random(seed) & 3) != 0) z = {3'b000, z[7:6], 1'b0, z[4:3], 1'b0, z[1:0]};
    return z;
  endfunction

  function automatic logic [31:0] mk_opv();
    logic [31:0] w;
    w = $random(seed);
    return {w[31:15], 3'(w[14:12] % 7), w[11:7], `VFRONT_OPV};
  endfunction

  // kind 1 vsetvli, 2 vsetivli, 3 vsetvl
  task automatic run_cfg(input int kind, input int delay);
    logic [31:0] instr, rs1, rs2, w;
    logic [10:0] zimm;
    logic [3:0]  id;
    int          waited;
    w    = $random(seed);
    rs1  = $random(seed) & 32'h3f;
    rs2  = {($random(seed) & 7) == 0, 20'd0, rand_zimm()};
    zimm = rand_zimm();
    if (kind == 1) instr = {1'b0, zimm, w[19:15], 3'b111, w[11:7], `VFRONT_OPV};
    else if (kind == 2) instr = {2'b11, zimm[9:0], w[19:15], 3'b111, w[11:7], `VFRONT_OPV};
    else instr = {7'b1000000, w[24:15], 3'b111, w[11:7], `VFRONT_OPV};
    id = next_id;
    issue(instr, rs1, rs2, waited);
    if (kind != 2) send_regs_late(id, rs1, rs2, delay);
    commit_next();
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk_i);
    step();
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_err_base) begin
      tests_passed++;
      $display("Test %0d %s: PASS", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", num, name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  initial begin
    int waited;
    held_valid = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    step();

    // 1: foreign opcodes are taken without accept
    for (int i = 0; i < 3; i++) issue({25'($random(seed)), 7'h33}, 0, 0, waited);
    repeat (4) step();
    drain();
    end_test(1, "non OP-V");

    // 2: vsetvli results, vl and vtype
    for (int i = 0; i < 12; i++) run_cfg(1, 0);
    drain();
    end_test(2, "vsetvli");

    // 3: vsetivli does not stall the next issue
    for (int i = 0; i < 5; i++) begin
      run_cfg(2, 0);
      issue(mk_opv(), 0, 0, waited);
      check_val("issue_ready_o", waited == 0, 1);
      commit_next();
    end
    drain();
    end_test(3, "vsetivli and OP-V order");

    // 4: stall until the matching register transfer
    for (int i = 0; i < 6; i++) run_cfg((i % 2) ? 3 : 1, 1 + ($random(seed) & 3));
    drain();
    end_test(4, "vsetvl stall");

    // 5: kill drops uncommitted instructions and the stall
    rr_mode = 1;
    for (int i = 0; i < 2; i++) begin
      issue(mk_opv(), 0, 0, waited);
      commit_next();
    end
    issue(mk_opv(), 0, 0, waited);
    issue({1'b0, 11'h010, 5'd3, 3'b111, 5'd1, `VFRONT_OPV}, 5, 0, waited);
    kill_all();
    issue({2'b11, 10'h008, 5'd4, 3'b111, 5'd2, `VFRONT_OPV}, 0, 0, waited);
    check_val("issue_ready_o", waited == 0, 1);
    commit_next();
    drain();
    end_test(5, "kill");

    // 6: full buffer and random result back-pressure
    rr_mode = 2;
    for (int i = 0; i < 8; i++) issue(mk_opv(), 0, 0, waited);
    issue_valid_i = 1'b1;
    issue_instr_i = mk_opv();
    issue_id_i    = next_id;
    repeat (3) begin
      @(negedge clk_i);
      check_val("issue_ready_o", issue_ready_o, 0);
      step();
    end
    issue_valid_i = 1'b0;
    for (int i = 0; i < 8; i++) commit_next();
    rr_mode = 1;
    for (int i = 0; i < 8; i++) begin
      if (i % 3 == 0) run_cfg(2, 0);
      else begin
        issue(mk_opv(), 0, 0, waited);
        commit_next();
      end
    end
    drain();
    end_test(6, "back-pressure");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : vfront_tb

/* run.sh */
#!/bin/sh
# Build and run the vfront testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module vfront_tb --Mdir obj_dir -o vfront_sim \
  -f vfront.f

out=$(./obj_dir/vfront_sim)
echo "$out"
echo "$out" | grep -q "^ALL TESTS PASSED$"

/* verilog/vfront_cfg_unit.sv */
////////////////////////////////////////////////////////////
// Configuration unit: executes vsetvli, vsetivli and
// vsetvl, holds vl and vtype, drives the result channel
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "vfront_macros.svh"

module vfront_cfg_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   disp_valid_i,
  input  vfront_pkg::buf_entry_t disp_entry_i,
  input  logic                   result_ready_i,
  output logic                   disp_ready_o,
  output logic                   result_valid_o,
  output vfront_pkg::id_t        result_id_o,
  output logic [4:0]             result_rd_o,
  output logic                   result_we_o,
  output vfront_pkg::xlen_t      result_data_o,
  output vfront_pkg::xlen_t      vl_o,
  output vfront_pkg::vtype_t     vtype_o
);

  logic               take;
  logic               is_cfg;
  logic               legal;
  logic [4:0]         rs1_field;
  logic [4:0]         rd_field;
  vfront_pkg::xlen_t  vt_raw;
  vfront_pkg::vtype_t vt_new;
  vfront_pkg::vtype_t vt_final;
  vfront_pkg::xlen_t  max_vl;
  vfront_pkg::xlen_t  avl;
  vfront_pkg::xlen_t  vl_new;

  // One result register, refilled as it drains
  assign disp_ready_o = !result_valid_o || result_ready_i;
  assign take         = disp_valid_i && disp_ready_o;

  assign is_cfg    = (disp_entry_i.kind != vfront_pkg::CFG_NONE);
  assign rs1_field = disp_entry_i.instr[19:15];
  assign rd_field  = disp_entry_i.instr[11:7];

  // Raw vtype from zimm, or from rs2 for vsetvl
  always_comb begin
    case (disp_entry_i.kind)
      vfront_pkg::CFG_VSETVLI:  vt_raw = vfront_pkg::xlen_t'(disp_entry_i.instr[30:20]);
      vfront_pkg::CFG_VSETIVLI: vt_raw = vfront_pkg::xlen_t'(disp_entry_i.instr[29:20]);
      default:                  vt_raw = disp_entry_i.rs2;
    endcase
  end

  // Any set bit above the vma field makes vtype illegal
  assign vt_new.vill  = |vt_raw[`VFRONT_XLEN-1:8];
  assign vt_new.vma   = vt_raw[7];
  assign vt_new.vta   = vt_raw[6];
  assign vt_new.vsew  = vt_raw[5:3];
  assign vt_new.vlmul = vt_raw[2:0];

  assign max_vl = vfront_pkg::vlmax(vt_new);
  assign legal  = vfront_pkg::vtype_legal(vt_new);

  // AVL selection
  always_comb begin
    if (disp_entry_i.kind == vfront_pkg::CFG_VSETIVLI) begin
      avl = vfront_pkg::xlen_t'(rs1_field);
    end else if (rs1_field == 5'd0) begin
      avl = max_vl;
    end else begin
      avl = disp_entry_i.rs1;
    end
  end

  always_comb begin
    vt_final = vt_new;
    vl_new   = (avl < max_vl) ? avl : max_vl;
    if (!legal) begin
      vt_final = '{vill: 1'b1, default: '0};
      vl_new   = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // State and result registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
      vl_o           <= '0;
      vtype_o        <= '{vill: 1'b1, default: '0};
    end else begin
      if (take) begin
        result_valid_o <= 1'b1;
      end else if (result_ready_i) begin
        result_valid_o <= 1'b0;
      end
      if (take && is_cfg) begin
        vl_o    <= vl_new;
        vtype_o <= vt_final;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      result_id_o   <= disp_entry_i.id;
      result_rd_o   <= rd_field;
      result_we_o   <= is_cfg && (rd_field != 5'd0);
      result_data_o <= is_cfg ? vl_new : '0;
    end
  end

  // Held result must not change until the core takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && !result_ready_i |=> result_valid_o &&
      $stable({result_id_o, result_rd_o, result_we_o, result_data_o}));

endmodule : vfront_cfg_unit

/* verilog/vfront_instr_buffer.sv */
////////////////////////////////////////////////////////////
// In-order ring buffer of issued instructions
// Operands and commit marks are written by id, the head
// leaves once committed and its operands are present
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "vfront_macros.svh"

module vfront_instr_buffer #(
  parameter int unsigned DEPTH = `VFRONT_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  vfront_pkg::buf_entry_t entry_i,
  output logic                   full_o,
  input  logic                   register_valid_i,
  input  vfront_pkg::id_t        register_id_i,
  input  vfront_pkg::xlen_t      register_rs1_i,
  input  vfront_pkg::xlen_t      register_rs2_i,
  input  logic                   commit_valid_i,
  input  vfront_pkg::id_t        commit_id_i,
  input  logic                   commit_kill_i,
  input  logic                   disp_ready_i,
  output logic                   disp_valid_o,
  output vfront_pkg::buf_entry_t disp_entry_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  vfront_pkg::buf_entry_t mem_q [DEPTH];
  vfront_pkg::buf_entry_t mem_d [DEPTH];

  // Pointers carry one extra wrap bit
  logic [PTR_W:0]   head_q, tail_q;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   keep_cnt;
  logic [PTR_W-1:0] head_idx, tail_idx;
  logic [DEPTH-1:0] live;
  logic             empty;
  logic             kill;
  logic             pop;

  assign head_idx = head_q[PTR_W-1:0];
  assign tail_idx = tail_q[PTR_W-1:0];
  assign count    = tail_q - head_q;
  assign empty    = (head_q == tail_q);
  assign full_o   = (count == (PTR_W+1)'(DEPTH));
  assign kill     = commit_valid_i && commit_kill_i;

  // Slots between head and tail
  always_comb begin : live_calc
    logic [PTR_W-1:0] offs;
    for (int i = 0; i < DEPTH; i++) begin
      offs    = PTR_W'(i) - head_idx;
      live[i] = {1'b0, offs} < count;
    end
  end

  // Commits come in order, so the committed run starts at the head
  always_comb begin : keep_calc
    logic [PTR_W-1:0] slot;
    logic             run;
    keep_cnt = '0;
    run      = 1'b1;
    for (int k = 0; k < DEPTH; k++) begin
      slot = head_idx + PTR_W'(k);
      if (run && live[slot] && mem_q[slot].committed) begin
        keep_cnt = keep_cnt + 1'b1;
      end else begin
        run = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry updates
  ////////////////////////////////////////////////////////////

  always_comb begin : entry_update
    logic wr_here;
    mem_d = mem_q;
    for (int i = 0; i < DEPTH; i++) begin
      wr_here = push_i && (tail_idx == PTR_W'(i));
      if (wr_here) begin
        mem_d[i] = entry_i;
      end
      // A pushed entry can see its operands or commit at once
      if (live[i] || wr_here) begin
        if (register_valid_i && (mem_d[i].id == register_id_i)) begin
          mem_d[i].rs1      = register_rs1_i;
          mem_d[i].rs2      = register_rs2_i;
          mem_d[i].rs_valid = 1'b1;
        end
        if (commit_valid_i && !commit_kill_i && (mem_d[i].id == commit_id_i)) begin
          mem_d[i].committed = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    mem_q <= mem_d;
  end

  ////////////////////////////////////////////////////////////
  // Dispatch and pointers
  ////////////////////////////////////////////////////////////

  assign disp_entry_o = mem_q[head_idx];
  assign disp_valid_o = !empty && disp_entry_o.committed &&
                        (disp_entry_o.rs_valid || !disp_entry_o.needs_rs);
  assign pop          = disp_valid_o && disp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      // Drop everything behind the committed run
      if (kill) begin
        tail_q <= head_q + keep_cnt;
      end else if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  // Issue control must hold back a push into a full buffer
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);

  // Dispatched head belongs to the run that a kill keeps
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    disp_valid_o |-> keep_cnt != '0);

endmodule : vfront_instr_buffer

/* verilog/vfront_issue_ctrl.sv */
////////////////////////////////////////////////////////////
// Issue ready and push logic, vsetvl stall FSM
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vfront_issue_ctrl (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            issue_valid_i,
  input  vfront_pkg::id_t issue_id_i,
  input  logic            accept_i,
  input  logic            needs_rs_i,
  input  logic            full_i,
  input  logic            register_valid_i,
  input  vfront_pkg::id_t register_id_i,
  input  logic            commit_valid_i,
  input  logic            commit_kill_i,
  output logic            issue_ready_o,
  output logic            push_o
);

  typedef enum logic {
    ST_OPEN,
    ST_STALL
  } stall_state_e;

  stall_state_e    state_q, state_d;
  vfront_pkg::id_t wait_id_q, wait_id_d;
  logic            kill;
  logic            reg_hit_wait;
  logic            reg_hit_issue;

  assign kill          = commit_valid_i && commit_kill_i;
  assign issue_ready_o = issue_valid_i && !full_i && (state_q == ST_OPEN) && !kill;
  assign push_o        = issue_ready_o && accept_i;

  assign reg_hit_wait  = register_valid_i && (register_id_i == wait_id_q);
  // Operands may come in the very cycle of the issue
  assign reg_hit_issue = register_valid_i && (register_id_i == issue_id_i);

  always_comb begin
    state_d   = state_q;
    wait_id_d = wait_id_q;
    case (state_q)
      ST_OPEN: begin
        if (push_o && needs_rs_i && !reg_hit_issue) begin
          state_d   = ST_STALL;
          wait_id_d = issue_id_i;
        end
      end
      ST_STALL: begin
        if (reg_hit_wait || kill) begin
          state_d = ST_OPEN;
        end
      end
      default: state_d = ST_OPEN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_OPEN;
      wait_id_q <= '0;
    end else begin
      state_q   <= state_d;
      wait_id_q <= wait_id_d;
    end
  end

  // A vsetvl waiting for its AVL blocks the next issue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o && needs_rs_i && !reg_hit_issue |=> !issue_ready_o);

endmodule : vfront_issue_ctrl

/* verilog/vfront_macros.svh */
////////////////////////////////////////////////////////////
// Width, depth and encoding constants of the vector
// front end
////////////////////////////////////////////////////////////

`ifndef VFRONT_MACROS_SVH
`define VFRONT_MACROS_SVH

// Scalar register width
`define VFRONT_XLEN 32

// Instruction id width, as driven by the core
`define VFRONT_ID_W 4

// Entries of the instruction ring buffer
`define VFRONT_DEPTH 8

// Vector register length in bits
`define VFRONT_VLEN 128

// Major opcode and funct3 of the configuration forms
`define VFRONT_OPV 7'h57
`define VFRONT_F3_CFG 3'b111

`endif

/* verilog/vfront_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the vector front end: instruction, id,
// vtype fields, configuration kinds and the buffer entry
// Helpers for VLMAX and vtype legality
////////////////////////////////////////////////////////////

`include "vfront_macros.svh"

package vfront_pkg;

  typedef logic [31:0]             instr_t;
  typedef logic [`VFRONT_ID_W-1:0] id_t;
  typedef logic [`VFRONT_XLEN-1:0] xlen_t;

  // Low bits of the vtype CSR, vill moved next to them
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  typedef enum logic [1:0] {
    CFG_NONE,
    CFG_VSETVLI,
    CFG_VSETIVLI,
    CFG_VSETVL
  } cfg_kind_e;

  // One issued instruction waiting for commit and operands
  typedef struct packed {
    instr_t    instr;
    id_t       id;
    cfg_kind_e kind;
    logic      needs_rs;
    xlen_t     rs1;
    xlen_t     rs2;
    logic      rs_valid;
    logic      committed;
  } buf_entry_t;

  // VLEN / SEW * LMUL, zero for reserved encodings
  function automatic xlen_t vlmax(vtype_t vt);
    xlen_t elems;
    if (vt.vsew[2] || vt.vlmul[2]) begin
      return '0;
    end
    elems = xlen_t'(`VFRONT_VLEN) >> (3 + vt.vsew);
    return elems << vt.vlmul;
  endfunction

  // Only integer LMUL and SEW up to 64 are supported
  function automatic logic vtype_legal(vtype_t vt);
    return !vt.vill && !vt.vsew[2] && !vt.vlmul[2];
  endfunction

endpackage : vfront_pkg

/* verilog/vfront_pre_decoder.sv */
////////////////////////////////////////////////////////////
// Pre-decoder of the offered instruction: OP-V accept,
// configuration kind, writeback and operand requests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "vfront_macros.svh"

module vfront_pre_decoder (
  input  logic                  issue_valid_i,
  input  vfront_pkg::instr_t    issue_instr_i,
  output logic                  accept_o,
  output logic                  writeback_o,
  output logic [1:0]            register_read_o,
  output vfront_pkg::cfg_kind_e kind_o,
  output logic                  needs_rs_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic       is_opv;
  logic       is_cfg;

  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];
  assign rd     = issue_instr_i[11:7];

  assign is_opv = issue_valid_i && (opcode == `VFRONT_OPV);
  assign is_cfg = is_opv && (funct3 == `VFRONT_F3_CFG);

  // Configuration forms differ in the top instruction bits
  always_comb begin
    kind_o = vfront_pkg::CFG_NONE;
    if (is_cfg) begin
      if (!issue_instr_i[31]) begin
        kind_o = vfront_pkg::CFG_VSETVLI;
      end else if (issue_instr_i[30]) begin
        kind_o = vfront_pkg::CFG_VSETIVLI;
      end else if (issue_instr_i[30:25] == 6'b000000) begin
        kind_o = vfront_pkg::CFG_VSETVL;
      end
    end
  end

  // Bit 0 requests rs1, bit 1 requests rs2
  always_comb begin
    case (kind_o)
      vfront_pkg::CFG_VSETVLI: register_read_o = 2'b01;
      vfront_pkg::CFG_VSETVL:  register_read_o = 2'b11;
      default:                 register_read_o = 2'b00;
    endcase
  end

  assign needs_rs_o  = |register_read_o;
  assign writeback_o = (kind_o != vfront_pkg::CFG_NONE) && (rd != 5'd0);
  assign accept_o    = is_opv;

endmodule : vfront_pre_decoder

/* verilog/vfront_top.sv */
////////////////////////////////////////////////////////////
// Vector front end top level
// Pre-decoder, issue control, ring buffer and
// configuration unit on the core's issue, register,
// commit and result channels
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "vfront_macros.svh"

module vfront_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Issue channel
  input  logic               issue_valid_i,
  input  vfront_pkg::instr_t issue_instr_i,
  input  vfront_pkg::id_t    issue_id_i,
  output logic               issue_ready_o,
  output logic               issue_accept_o,
  output logic               issue_writeback_o,
  output logic [1:0]         issue_register_read_o,
  // Register channel
  input  logic               register_valid_i,
  input  vfront_pkg::id_t    register_id_i,
  input  vfront_pkg::xlen_t  register_rs1_i,
  input  vfront_pkg::xlen_t  register_rs2_i,
  output logic               register_ready_o,
  // Commit channel
  input  logic               commit_valid_i,
  input  vfront_pkg::id_t    commit_id_i,
  input  logic               commit_kill_i,
  // Result channel
  output logic               result_valid_o,
  output vfront_pkg::id_t    result_id_o,
  output logic [4:0]         result_rd_o,
  output logic               result_we_o,
  output vfront_pkg::xlen_t  result_data_o,
  input  logic               result_ready_i,
  // Status
  output vfront_pkg::xlen_t  vl_o,
  output vfront_pkg::vtype_t vtype_o
);

  vfront_pkg::cfg_kind_e  dec_kind;
  vfront_pkg::buf_entry_t push_entry;
  vfront_pkg::buf_entry_t disp_entry;
  logic                   dec_needs_rs;
  logic                   push;
  logic                   buf_full;
  logic                   disp_valid;
  logic                   disp_ready;

  // Operands are always taken on the spot
  assign register_ready_o = register_valid_i;

  // New entries start without operands and uncommitted
  assign push_entry = '{
    instr:     issue_instr_i,
    id:        issue_id_i,
    kind:      dec_kind,
    needs_rs:  dec_needs_rs,
    rs1:       '0,
    rs2:       '0,
    rs_valid:  1'b0,
    committed: 1'b0
  };

  vfront_pre_decoder vfront_pre_decoder_inst (
    .issue_valid_i  (issue_valid_i),
    .issue_instr_i  (issue_instr_i),
    .accept_o       (issue_accept_o),
    .writeback_o    (issue_writeback_o),
    .register_read_o(issue_register_read_o),
    .kind_o         (dec_kind),
    .needs_rs_o     (dec_needs_rs)
  );

  vfront_issue_ctrl vfront_issue_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_valid_i   (issue_valid_i),
    .issue_id_i      (issue_id_i),
    .accept_i        (issue_accept_o),
    .needs_rs_i      (dec_needs_rs),
    .full_i          (buf_full),
    .register_valid_i(register_valid_i),
    .register_id_i   (register_id_i),
    .commit_valid_i  (commit_valid_i),
    .commit_kill_i   (commit_kill_i),
    .issue_ready_o   (issue_ready_o),
    .push_o          (push)
  );

  vfront_instr_buffer #(
    .DEPTH(`VFRONT_DEPTH)
  ) vfront_instr_buffer_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .entry_i         (push_entry),
    .full_o          (buf_full),
    .register_valid_i(register_valid_i),
    .register_id_i   (register_id_i),
    .register_rs1_i  (register_rs1_i),
    .register_rs2_i  (register_rs2_i),
    .commit_valid_i  (commit_valid_i),
    .commit_id_i     (commit_id_i),
    .commit_kill_i   (commit_kill_i),
    .disp_ready_i    (disp_ready),
    .disp_valid_o    (disp_valid),
    .disp_entry_o    (disp_entry)
  );

  vfront_cfg_unit vfront_cfg_unit_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .disp_valid_i  (disp_valid),
    .disp_entry_i  (disp_entry),
    .result_ready_i(result_ready_i),
    .disp_ready_o  (disp_ready),
    .result_valid_o(result_valid_o),
    .result_id_o   (result_id_o),
    .result_rd_o   (result_rd_o),
    .result_we_o   (result_we_o),
    .result_data_o (result_data_o),
    .vl_o          (vl_o),
    .vtype_o       (vtype_o)
  );

endmodule : vfront_top

/* vfront.f */
+incdir+verilog
+incdir+dv
verilog/vfront_pkg.sv
verilog/vfront_pre_decoder.sv
verilog/vfront_issue_ctrl.sv
verilog/vfront_instr_buffer.sv
verilog/vfront_cfg_unit.sv
verilog/vfront_top.sv
dv/vfront_tb.sv
